/* cnn_pkg.sv */
`default_nettype none

package cnn_pkg;

  // ############################################################
  // Stream geometry

  localparam int UNITS       = 4;
  localparam int ACC_WIDTH   = 20;
  localparam int OUT_WIDTH   = 8;
  localparam int POOL_LANES  = UNITS / 2;

  // Configuration word fields
  localparam int ALPHA_WIDTH = 3;
  localparam int SHIFT_WIDTH = 5;
  localparam int CFG_PAD     = UNITS * ACC_WIDTH - ALPHA_WIDTH - SHIFT_WIDTH;

  // Saturation limits of the requantised word
  localparam int Q_MAX       = 2 ** (OUT_WIDTH - 1) - 1;
  localparam int Q_MIN       = -(2 ** (OUT_WIDTH - 1));

  // ############################################################
  // Beat types

  typedef logic signed [ACC_WIDTH-1:0] acc_word_t;
  typedef acc_word_t [UNITS-1:0] acc_beat_t;

  typedef struct packed {
    logic [CFG_PAD-1:0]     pad;
    logic [ALPHA_WIDTH-1:0] alpha_shift;  // negative slope is 2^-alpha_shift
    logic [SHIFT_WIDTH-1:0] out_shift;
  } lrelu_cfg_t;

  // One input word read either as accumulator lanes or as configuration
  typedef union packed {
    acc_beat_t  acc;
    lrelu_cfg_t cfg;
  } conv_word_u;

  typedef struct packed {
    conv_word_u data;
    logic       is_cfg;
    logic       last;
  } conv_axis_t;

  typedef logic signed [OUT_WIDTH-1:0] q_word_t;
  typedef q_word_t [UNITS-1:0] q_beat_t;
  typedef q_word_t [POOL_LANES-1:0] pool_beat_t;

  typedef struct packed {
    q_beat_t data;
    logic    last;
  } q_axis_t;

  typedef struct packed {
    pool_beat_t data;
    logic       last;
  } pool_axis_t;

endpackage

`default_nettype wire

/* lrelu_requant.sv */
`timescale 1ns/1ps
`default_nettype none

module lrelu_requant (
  input  wire logic                aclk,
  input  wire logic                i_reset,
  input  wire cnn_pkg::conv_axis_t i_in,
  input  wire logic                i_in_valid,
  output logic                     o_in_ready,
  output cnn_pkg::q_axis_t         o_q,
  output logic                     o_q_valid,
  input  wire logic                i_q_ready
);

  logic [cnn_pkg::ALPHA_WIDTH-1:0] alpha_shift;
  logic [cnn_pkg::SHIFT_WIDTH-1:0] out_shift;

  logic                            in_take;
  logic                            cfg_take;
  logic                            data_take;

  logic                            s1_valid;
  logic                            s1_ready;
  logic                            s2_ready;
  cnn_pkg::acc_beat_t              s1_data;
  logic [cnn_pkg::SHIFT_WIDTH-1:0] s1_shift;
  logic                            s1_last;

  cnn_pkg::acc_beat_t              leaky_beat;
  cnn_pkg::q_beat_t                q_next;

  // Rounds half an LSB up, shifts and clamps to the output range
  function automatic cnn_pkg::q_word_t requant(cnn_pkg::acc_word_t v,
                                               logic [cnn_pkg::SHIFT_WIDTH-1:0] sh);
    int bias;
    int shifted;
    bias = (sh == '0) ? 0 : (1 <<< (sh - 1));
    shifted = (int'(v) + bias) >>> sh;
    if (shifted > cnn_pkg::Q_MAX) begin
      requant = cnn_pkg::q_word_t'(cnn_pkg::Q_MAX);
    end else if (shifted < cnn_pkg::Q_MIN) begin
      requant = cnn_pkg::q_word_t'(cnn_pkg::Q_MIN);
    end else begin
      requant = cnn_pkg::q_word_t'(shifted);
    end
  endfunction

  // ############################################################
  // Handshake

  assign s2_ready   = !o_q_valid || i_q_ready;
  assign s1_ready   = !s1_valid || s2_ready;
  assign o_in_ready = s1_ready;

  assign in_take    = i_in_valid && o_in_ready;
  assign cfg_take   = in_take && i_in.is_cfg;
  assign data_take  = in_take && !i_in.is_cfg;

  // ############################################################
  // Stage 1 applies the leaky slope to negative lanes

  always_comb begin
    for (int i = 0; i < cnn_pkg::UNITS; i++) begin
      if (i_in.data.acc[i][cnn_pkg::ACC_WIDTH-1]) begin
        leaky_beat[i] = $signed(i_in.data.acc[i]) >>> alpha_shift;
      end else begin
        leaky_beat[i] = i_in.data.acc[i];
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      alpha_shift <= '0;
      out_shift   <= '0;
      s1_valid    <= 1'b0;
    end else begin
      if (cfg_take) begin
        alpha_shift <= i_in.data.cfg.alpha_shift;
        out_shift   <= i_in.data.cfg.out_shift;
      end
      if (s1_ready) begin
        s1_valid <= data_take;
      end
    end
  end

  // The output shift travels with the beat so a later config cannot reach it
  always_ff @(posedge aclk) begin
    if (data_take) begin
      s1_data  <= leaky_beat;
      s1_shift <= out_shift;
      s1_last  <= i_in.last;
    end
  end

  // ############################################################
  // Stage 2 rounds, shifts and saturates

  always_comb begin
    for (int i = 0; i < cnn_pkg::UNITS; i++) begin
      q_next[i] = requant(s1_data[i], s1_shift);
    end
  end

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      o_q_valid <= 1'b0;
    end else if (s2_ready) begin
      o_q_valid <= s1_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (s2_ready && s1_valid) begin
      o_q.data <= q_next;
      o_q.last <= s1_last;
    end
  end

  a_q_stable : assert property (@(posedge aclk) disable iff (i_reset)
    o_q_valid && !i_q_ready |=> o_q_valid && $stable(o_q));

endmodule

`default_nettype wire

/* maxpool_2x2.sv */
`timescale 1ns/1ps
`default_nettype none

module maxpool_2x2 (
  input  wire logic             aclk,
  input  wire logic             i_reset,
  input  wire cnn_pkg::q_axis_t i_q,
  input  wire logic             i_q_valid,
  output logic                  o_q_ready,
  output cnn_pkg::pool_axis_t   o_out,
  output logic                  o_out_valid,
  input  wire logic             i_out_ready
);

  // High while the first column of a pair is held
  logic                phase;
  logic                take;
  cnn_pkg::q_beat_t    first_beat;
  cnn_pkg::pool_beat_t pooled;

  function automatic cnn_pkg::q_word_t max2(cnn_pkg::q_word_t a, cnn_pkg::q_word_t b);
    max2 = (a > b) ? a : b;
  endfunction

  assign o_q_ready = !o_out_valid || i_out_ready;
  assign take      = i_q_valid && o_q_ready;

  // ############################################################
  // Window maxima over two lanes of two columns

  always_comb begin
    for (int k = 0; k < cnn_pkg::POOL_LANES; k++) begin
      pooled[k] = max2(max2(first_beat[2*k], first_beat[2*k+1]),
                       max2(i_q.data[2*k], i_q.data[2*k+1]));
    end
  end

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      phase       <= 1'b0;
      o_out_valid <= 1'b0;
    end else begin
      if (take) begin
        phase <= !phase;
      end
      if (o_q_ready) begin
        o_out_valid <= take && phase;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (take && !phase) begin
      first_beat <= i_q.data;
    end
    if (take && phase) begin
      o_out.data <= pooled;
      o_out.last <= i_q.last;
    end
  end

  // Packets always hold an even number of columns
  a_last_on_second : assert property (@(posedge aclk) disable iff (i_reset)
    take && !phase |-> !i_q.last);

  a_out_stable : assert property (@(posedge aclk) disable iff (i_reset)
    o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out));

endmodule

`default_nettype wire

/* cnn_post_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_post_top (
  input  wire logic                aclk,
  input  wire logic                i_reset,
  input  wire cnn_pkg::conv_axis_t i_in,
  input  wire logic                i_in_valid,
  output logic                     o_in_ready,
  output cnn_pkg::pool_axis_t      o_out,
  output logic                     o_out_valid,
  input  wire logic                i_out_ready
);

  // Requantised stream between the two stages
  cnn_pkg::q_axis_t mid_q;
  logic             mid_valid;
  logic             mid_ready;

  lrelu_requant u_lrelu_requant (
    .aclk       (aclk),
    .i_reset    (i_reset),
    .i_in       (i_in),
    .i_in_valid (i_in_valid),
    .o_in_ready (o_in_ready),
    .o_q        (mid_q),
    .o_q_valid  (mid_valid),
    .i_q_ready  (mid_ready)
  );

  maxpool_2x2 u_maxpool_2x2 (
    .aclk        (aclk),
    .i_reset     (i_reset),
    .i_q         (mid_q),
    .i_q_valid   (mid_valid),
    .o_q_ready   (mid_ready),
    .o_out       (o_out),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready)
  );

endmodule

`default_nettype wire

/* cnn_post_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cnn_post_checker (
  input wire logic                aclk,
  input wire logic                i_reset,
  input wire cnn_pkg::pool_axis_t i_out,
  input wire logic                i_out_valid,
  input wire logic                i_out_ready
);

  typedef logic [8*16-1:0] name_t;

  // Expected beats in output order as the testbench queues them
  name_t       name_q [$];
  logic        last_q [$];
  logic [15:0] data_q [$];

  int          mismatch_count;
  int          extra_count;
  int          beat_count;

  name_t       exp_name;
  logic        exp_last;
  logic [15:0] exp_data;

  task automatic expect_beat(input name_t name, input logic last, input logic [15:0] data);
    name_q.push_back(name);
    last_q.push_back(last);
    data_q.push_back(data);
  endtask

  function automatic int pending();
    return name_q.size();
  endfunction

  task automatic report_leftover();
    for (int i = 0; i < name_q.size(); i++) begin
      $display("Expected beat of test %0s with data %h never appeared on the output",
               name_q[i], data_q[i]);
    end
  endtask

  // ############################################################
  // Compare every accepted output beat

  always @(posedge aclk) begin
    if (!i_reset && i_out_valid && i_out_ready) begin
      beat_count++;
      if (name_q.size() == 0) begin
        extra_count++;
        $display("Output beat %0d with data %h arrived after all expected beats were used",
                 beat_count, i_out.data);
      end else begin
        exp_name = name_q.pop_front();
        exp_last = last_q.pop_front();
        exp_data = data_q.pop_front();
        if (i_out.data != exp_data || i_out.last != exp_last) begin
          mismatch_count++;
          $display("ERR %0s expected data %h last %0d actual data %h last %0d",
                   exp_name, exp_data, exp_last, i_out.data, i_out.last);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tb_cnn_post.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cnn_post;

  typedef logic [8*16-1:0] name_t;
  localparam int MAX_CMDS = 64;

  logic                aclk;
  logic                i_reset;
  cnn_pkg::conv_axis_t i_in;
  logic                i_in_valid;
  logic                o_in_ready;
  cnn_pkg::pool_axis_t o_out;
  logic                o_out_valid;
  logic                i_out_ready;

  // Input beats and idle gaps in file order
  logic [7:0]  cmd_kind [MAX_CMDS];
  name_t       cmd_name [MAX_CMDS];
  logic        cmd_cfg  [MAX_CMDS];
  logic        cmd_last [MAX_CMDS];
  logic [79:0] cmd_word [MAX_CMDS];
  int          cmd_gap  [MAX_CMDS];
  int          n_cmds;
  int          n_lines;
  int          file_errors;

  int          seed = 47;
  logic        bp_on;
  int          cycle_count;
  int          cycle_limit;
  int          total_errors;

  cnn_post_top DUT (
    .aclk        (aclk),
    .i_reset     (i_reset),
    .i_in        (i_in),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .o_out       (o_out),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready)
  );

  cnn_post_checker u_checker (
    .aclk        (aclk),
    .i_reset     (i_reset),
    .i_out       (o_out),
    .i_out_valid (o_out_valid),
    .i_out_ready (i_out_ready)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  // ############################################################
  // Pattern file

  task automatic read_patterns();
    int          fd;
    int          code;
    int          want;
    int          cfg_i;
    int          last_i;
    logic [7:0]  kind;
    name_t       name;
    logic [19:0] l3;
    logic [19:0] l2;
    logic [19:0] l1;
    logic [19:0] l0;
    logic [7:0]  e1;
    logic [7:0]  e0;
    logic [8*160-1:0] rest;
    fd = $fopen("cnn_post_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file cnn_post_patterns.txt");
      file_errors++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", kind);
      if (code == 1) begin
        want = 1;
        case (kind)
          "#": code = $fgets(rest, fd);
          "I": begin
            want = 7;
            code = $fscanf(fd, "%s %d %d %h %h %h %h", name, cfg_i, last_i, l3, l2, l1, l0);
            cmd_kind[n_cmds] = "I";
            cmd_name[n_cmds] = name;
            cmd_cfg[n_cmds]  = cfg_i[0];
            cmd_last[n_cmds] = last_i[0];
            cmd_word[n_cmds] = {l3, l2, l1, l0};
            n_cmds++;
          end
          "E": begin
            want = 4;
            code = $fscanf(fd, "%s %d %h %h", name, last_i, e1, e0);
            u_checker.expect_beat(name, last_i[0], {e1, e0});
          end
          "G": begin
            code = $fscanf(fd, "%d", cmd_gap[n_cmds]);
            cmd_kind[n_cmds] = "G";
            n_cmds++;
          end
          default: begin
            $display("The pattern file holds a line of unknown kind");
            file_errors++;
          end
        endcase
        if (kind != "#") begin
          n_lines++;
        end
        if (code < want) begin
          $display("A line of the pattern file could not be read completely");
          file_errors++;
        end
      end
    end
    $fclose(fd);
  endtask

  // ############################################################
  // Stream driving

  // Called 1 ns after a rising edge and returns 1 ns after the accepting edge
  task automatic send_beat(input logic is_cfg, input logic last, input logic [79:0] word);
    logic accepted;
    i_in.data.acc = word;
    i_in.is_cfg   = is_cfg;
    i_in.last     = last;
    i_in_valid    = 1'b1;
    accepted      = 1'b0;
    while (!accepted) begin
      @(negedge aclk);
      accepted = o_in_ready;
      @(posedge aclk);
      #1;
    end
    i_in_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge aclk);
      #1;
    end
  endtask

  always @(posedge aclk) begin
    #1;
    if (bp_on) begin
      i_out_ready = ($unsigned($random(seed)) % 100) < 70;
    end else begin
      i_out_ready = 1'b1;
    end
  end

  always @(posedge aclk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Run stopped after %0d cycles with %0d expected beats still outstanding",
               cycle_count, u_checker.pending());
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    i_reset     = 1'b1;
    i_in        = '0;
    i_in_valid  = 1'b0;
    i_out_ready = 1'b1;
    bp_on       = 1'b0;
    read_patterns();
    cycle_limit = 30 * n_lines + 200;
    repeat (16) @(posedge aclk);
    #1;
    i_reset = 1'b0;
    for (int c = 0; c < n_cmds; c++) begin
      if (cmd_kind[c] == "G") begin
        idle_cycles(cmd_gap[c]);
      end else begin
        bp_on = (cmd_name[c] == name_t'("backpressure"));
        send_beat(cmd_cfg[c], cmd_last[c], cmd_word[c]);
      end
    end
    while (u_checker.pending() != 0) begin
      @(posedge aclk);
    end
    // Leave room for any surplus beats to show up
    repeat (20) @(posedge aclk);
    u_checker.report_leftover();
    total_errors = u_checker.mismatch_count + u_checker.extra_count
                 + u_checker.pending() + file_errors;
    $display("Errors: %0d mismatched, %0d unexpected, %0d missing, %0d in pattern file",
             u_checker.mismatch_count, u_checker.extra_count, u_checker.pending(),
             file_errors);
    if (total_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cnn_post_patterns.txt */
# I test cfg last lane3 lane2 lane1 lane0 : input beat, hex accumulator lanes, lane0 holds config
# E test last lane1 lane0 : expected pooled beat, hex   G n : n idle input cycles
I requant 1 0 00000 00000 00000 00004
I requant 0 0 00018 00007 00100 00028
I requant 0 0 00030 00010 0003F 00008
E requant 0 03 10
I requant 0 0 00000 00017 00008 00007
I requant 0 1 00009 00000 00018 00005
E requant 1 01 02
I leaky 1 0 00000 00000 00000 00062
I leaky 0 0 FFF80 00014 FFFC4 FFF00
I leaky 0 1 FFFFF 00007 FFFD0 FFE00
E leaky 1 05 FF
G 3
I saturate 1 0 00000 00000 00000 00000
I saturate 0 0 80001 80000 80000 7FFFF
I saturate 0 1 FFF7F FFF00 00003 00050
E saturate 1 80 7F
I pool_last 1 0 00000 00000 00000 00000
I pool_last 0 0 00005 FFFFD 00010 00002
I pool_last 0 0 00001 00007 00003 00011
E pool_last 0 07 11
I pool_last 0 0 FFFF0 FFFF8 FFFFE FFFFC
I pool_last 0 1 FFFF9 FFFFA FFFFB FFFF6
E pool_last 1 FA FE
I pool_last 0 0 0000A 00000 00000 0000B
I pool_last 0 1 00000 0000C 00009 00000
E pool_last 1 0C 0B
I backpressure 1 0 00000 00000 00000 00021
I backpressure 0 0 00002 00004 00006 00008
I backpressure 0 0 0000A 00001 00003 00005
E backpressure 0 05 04
I backpressure 0 0 FFFF8 00014 FFFFC 0001E
I backpressure 0 0 FFFF0 FFFE0 00028 00000
E backpressure 0 0A 14
I backpressure 0 0 00064 00032 000C8 0012C
I backpressure 0 0 00001 00001 00001 00001
E backpressure 0 32 7F
I backpressure 0 0 FFF00 FFF00 FFF00 FFF00
I backpressure 0 1 FFE00 FFE00 FFE00 FFE00
E backpressure 1 C0 C0
G 20
I cfg_between 1 0 00000 00000 00000 00000
I cfg_between 0 0 00010 00020 00030 00040
I cfg_between 0 1 00004 00008 0000C 00050
E cfg_between 1 20 50
I cfg_between 1 0 00000 00000 00000 00002
I cfg_between 0 0 00010 00020 00030 00040
I cfg_between 0 1 00004 00008 0000C 00050
E cfg_between 1 08 14

/* vlog.f */
cnn_pkg.sv
lrelu_requant.sv
maxpool_2x2.sv
cnn_post_top.sv
cnn_post_checker.sv
tb_cnn_post.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_cnn_post -f vlog.f || exit 1
out=$(./obj_dir/Vtb_cnn_post 2>&1)
echo "$out"
echo "$out" | grep -q "SIMULATION PASSED" && exit 0 || exit 1
